//--- flist.f
rs_cfg_pkg.sv
rs_types_pkg.sv
rs_station.sv
phys_regfile.sv
rs_issue_top.sv
tb_rs_issue_top.sv

//--- phys_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module phys_regfile (
  input  logic                                clk,
  input  logic                                arst_n,
  input  rs_types_pkg::cdb_pkt_t              cdb,
  input  logic [rs_cfg_pkg::PREG_W-1:0]       a_rs1,
  input  logic [rs_cfg_pkg::PREG_W-1:0]       a_rs2,
  input  logic [rs_cfg_pkg::PREG_W-1:0]       m_rs1,
  input  logic [rs_cfg_pkg::PREG_W-1:0]       m_rs2,
  output logic [rs_cfg_pkg::XLEN-1:0]         a_rs1_v,
  output logic [rs_cfg_pkg::XLEN-1:0]         a_rs2_v,
  output logic [rs_cfg_pkg::XLEN-1:0]         m_rs1_v,
  output logic [rs_cfg_pkg::XLEN-1:0]         m_rs2_v
);

  localparam int NREGS = 2 ** rs_cfg_pkg::PREG_W;

  logic [rs_cfg_pkg::XLEN-1:0] regs [NREGS];

  // p0 is never written, so it stays zero from reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rs_types_pkg::cdb_hit(cdb, cdb.tag)) begin
      regs[cdb.tag] <= cdb.value;
    end
  end

  // bypass the broadcast landing this cycle
  always_comb begin
    a_rs1_v = rs_types_pkg::cdb_hit(cdb, a_rs1) ? cdb.value : regs[a_rs1];
    a_rs2_v = rs_types_pkg::cdb_hit(cdb, a_rs2) ? cdb.value : regs[a_rs2];
    m_rs1_v = rs_types_pkg::cdb_hit(cdb, m_rs1) ? cdb.value : regs[m_rs1];
    m_rs2_v = rs_types_pkg::cdb_hit(cdb, m_rs2) ? cdb.value : regs[m_rs2];
  end

endmodule

`default_nettype wire

//--- rs_cfg_pkg.sv
`default_nettype none

// widths shared by the issue stage
package rs_cfg_pkg;

  // physical register tag, 64 registers
  localparam int PREG_W = 6;

  localparam int ROB_W = 5; // rob index
  localparam int XLEN = 32;

  // station depths used when the top is not overridden
  localparam int ARITH_DEPTH_DEF = 4;
  localparam int MULT_DEPTH_DEF = 2;

endpackage

`default_nettype wire

//--- rs_issue_top.sv
`timescale 1ns/1ps
`default_nettype none

module rs_issue_top #(
  parameter int ARITH_DEPTH = rs_cfg_pkg::ARITH_DEPTH_DEF,
  parameter int MULT_DEPTH  = rs_cfg_pkg::MULT_DEPTH_DEF
) (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        flush,
  input  logic                        issue_valid,
  input  rs_types_pkg::issue_pkt_t    issue_pkt,
  output logic                        issue_ready,
  input  rs_types_pkg::cdb_pkt_t      cdb,
  output logic                        arith_valid,
  output rs_types_pkg::dispatch_pkt_t arith_pkt,
  input  logic                        arith_ready,
  output logic                        mult_valid,
  output rs_types_pkg::dispatch_pkt_t mult_pkt,
  input  logic                        mult_ready
);

  logic arith_alloc_valid, arith_alloc_ready;
  logic mult_alloc_valid, mult_alloc_ready;

  rs_types_pkg::rs_entry_t arith_entry;
  rs_types_pkg::rs_entry_t mult_entry;

  logic [rs_cfg_pkg::XLEN-1:0] a_rs1_v, a_rs2_v;
  logic [rs_cfg_pkg::XLEN-1:0] m_rs1_v, m_rs2_v;

  // compares share the alu station
  always_comb begin
    arith_alloc_valid = 1'b0;
    mult_alloc_valid  = 1'b0;
    issue_ready       = 1'b0;
    case (issue_pkt.fu_sel)
      rs_types_pkg::fu_arith, rs_types_pkg::fu_comp: begin
        arith_alloc_valid = issue_valid;
        issue_ready       = arith_alloc_ready;
      end
      rs_types_pkg::fu_mult: begin
        mult_alloc_valid = issue_valid;
        issue_ready      = mult_alloc_ready;
      end
      default: ; // unused unit code is never accepted
    endcase
  end

  rs_station #(.DEPTH(ARITH_DEPTH)) u_arith_rs (
    .clk         (clk),
    .arst_n      (arst_n),
    .flush       (flush),
    .alloc_valid (arith_alloc_valid),
    .alloc_pkt   (issue_pkt),
    .alloc_ready (arith_alloc_ready),
    .cdb         (cdb),
    .sel_valid   (arith_valid),
    .sel_entry   (arith_entry),
    .sel_ready   (arith_ready)
  );

  rs_station #(.DEPTH(MULT_DEPTH)) u_mult_rs (
    .clk         (clk),
    .arst_n      (arst_n),
    .flush       (flush),
    .alloc_valid (mult_alloc_valid),
    .alloc_pkt   (issue_pkt),
    .alloc_ready (mult_alloc_ready),
    .cdb         (cdb),
    .sel_valid   (mult_valid),
    .sel_entry   (mult_entry),
    .sel_ready   (mult_ready)
  );

  // read ports follow whatever each station is presenting
  phys_regfile u_prf (
    .clk     (clk),
    .arst_n  (arst_n),
    .cdb     (cdb),
    .a_rs1   (arith_entry.rs1),
    .a_rs2   (arith_entry.rs2),
    .m_rs1   (mult_entry.rs1),
    .m_rs2   (mult_entry.rs2),
    .a_rs1_v (a_rs1_v),
    .a_rs2_v (a_rs2_v),
    .m_rs1_v (m_rs1_v),
    .m_rs2_v (m_rs2_v)
  );

  assign arith_pkt = rs_types_pkg::make_dispatch(arith_entry, a_rs1_v, a_rs2_v);
  assign mult_pkt  = rs_types_pkg::make_dispatch(mult_entry, m_rs1_v, m_rs2_v);

endmodule

`default_nettype wire

//--- rs_station.sv
`timescale 1ns/1ps
`default_nettype none

module rs_station #(
  parameter int DEPTH = rs_cfg_pkg::ARITH_DEPTH_DEF
) (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    flush,
  input  logic                    alloc_valid,
  input  rs_types_pkg::issue_pkt_t alloc_pkt,
  output logic                    alloc_ready,
  input  rs_types_pkg::cdb_pkt_t  cdb,
  output logic                    sel_valid,
  output rs_types_pkg::rs_entry_t sel_entry,
  input  logic                    sel_ready
);

  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  rs_types_pkg::rs_entry_t entries [DEPTH];
  rs_types_pkg::rs_entry_t new_entry;

  logic [IDX_W-1:0] free_idx;
  logic [IDX_W-1:0] pick_idx;
  logic             pick_found;
  logic [IDX_W-1:0] sel_idx;
  logic             hold_vld; // unit stalled last cycle
  logic [IDX_W-1:0] hold_idx;
  logic             take;

  // lowest free slot, scanned from the top so index 0 wins
  always_comb begin
    free_idx    = '0;
    alloc_ready = 1'b0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (!entries[i].busy) begin
        free_idx    = IDX_W'(i);
        alloc_ready = 1'b1;
      end
    end
  end

  // lowest entry with both operands in hand
  always_comb begin
    pick_idx   = '0;
    pick_found = 1'b0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (entries[i].busy && entries[i].rs1_rdy && entries[i].rs2_rdy) begin
        pick_idx   = IDX_W'(i);
        pick_found = 1'b1;
      end
    end
  end

  // a stalled entry keeps the output even if a lower one wakes
  assign sel_idx   = hold_vld ? hold_idx : pick_idx;
  assign sel_valid = hold_vld | pick_found;
  assign sel_entry = entries[sel_idx];
  assign take      = sel_valid & sel_ready;

  // incoming instruction also snoops this cycle's broadcast
  always_comb begin
    new_entry         = '0;
    new_entry.busy    = 1'b1;
    new_entry.fu_op   = alloc_pkt.fu_op;
    new_entry.rs1     = alloc_pkt.rs1;
    new_entry.rs2     = alloc_pkt.rs2;
    new_entry.rs1_rdy = alloc_pkt.rs1_rdy | rs_types_pkg::cdb_hit(cdb, alloc_pkt.rs1);
    new_entry.rs2_rdy = alloc_pkt.rs2_rdy | rs_types_pkg::cdb_hit(cdb, alloc_pkt.rs2);
    new_entry.rd      = alloc_pkt.rd;
    new_entry.rob     = alloc_pkt.rob;
    new_entry.use_imm = alloc_pkt.use_imm;
    new_entry.imm     = alloc_pkt.imm;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        entries[i] <= '0;
      end
      hold_vld <= 1'b0;
      hold_idx <= '0;
    end else if (flush) begin
      for (int i = 0; i < DEPTH; i++) begin
        entries[i].busy <= 1'b0;
      end
      hold_vld <= 1'b0;
    end else begin
      // wakeup
      for (int i = 0; i < DEPTH; i++) begin
        if (rs_types_pkg::cdb_hit(cdb, entries[i].rs1)) begin
          entries[i].rs1_rdy <= 1'b1;
        end
        if (rs_types_pkg::cdb_hit(cdb, entries[i].rs2)) begin
          entries[i].rs2_rdy <= 1'b1;
        end
      end
      if (take) begin
        entries[sel_idx].busy <= 1'b0;
      end
      // free slot is never the selected one, no conflict with take
      if (alloc_valid && alloc_ready) begin
        entries[free_idx] <= new_entry;
      end
      hold_vld <= sel_valid & ~sel_ready;
      hold_idx <= sel_idx;
    end
  end

endmodule

`default_nettype wire

//--- rs_types_pkg.sv
`default_nettype none

package rs_types_pkg;

  typedef enum logic [1:0] {fu_arith, fu_comp, fu_mult} fu_sel_e;

  typedef enum logic [3:0] {
    op_add, op_sub, op_and, op_or, op_xor, op_slt, op_mul, op_mulh
  } fu_op_e;

  // from rename
  typedef struct packed {
    fu_sel_e                       fu_sel;
    fu_op_e                        fu_op;
    logic [rs_cfg_pkg::PREG_W-1:0] rs1;
    logic [rs_cfg_pkg::PREG_W-1:0] rs2;
    logic                          rs1_rdy;
    logic                          rs2_rdy;
    logic [rs_cfg_pkg::PREG_W-1:0] rd;
    logic [rs_cfg_pkg::ROB_W-1:0]  rob;
    logic                          use_imm;
    logic [31:0]                   imm;
  } issue_pkt_t;

  typedef struct packed {
    logic                          valid;
    logic [rs_cfg_pkg::PREG_W-1:0] tag;
    logic [rs_cfg_pkg::XLEN-1:0]   value;
  } cdb_pkt_t;

  typedef struct packed {
    logic                          busy;
    fu_op_e                        fu_op;
    logic [rs_cfg_pkg::PREG_W-1:0] rs1;
    logic [rs_cfg_pkg::PREG_W-1:0] rs2;
    logic                          rs1_rdy;
    logic                          rs2_rdy;
    logic [rs_cfg_pkg::PREG_W-1:0] rd;
    logic [rs_cfg_pkg::ROB_W-1:0]  rob;
    logic                          use_imm;
    logic [31:0]                   imm;
  } rs_entry_t;

  // toward a functional unit
  typedef struct packed {
    fu_op_e                        fu_op;
    logic [rs_cfg_pkg::PREG_W-1:0] rd;
    logic [rs_cfg_pkg::ROB_W-1:0]  rob;
    logic                          use_imm;
    logic [31:0]                   imm;
    logic [rs_cfg_pkg::XLEN-1:0]   rs1_val;
    logic [rs_cfg_pkg::XLEN-1:0]   rs2_val;
  } dispatch_pkt_t;

  // tag 0 is never broadcast as a result
  function automatic logic cdb_hit(cdb_pkt_t c, logic [rs_cfg_pkg::PREG_W-1:0] tag);
    return c.valid && (c.tag != '0) && (c.tag == tag);
  endfunction

  function automatic dispatch_pkt_t make_dispatch(rs_entry_t e,
                                                  logic [rs_cfg_pkg::XLEN-1:0] v1,
                                                  logic [rs_cfg_pkg::XLEN-1:0] v2);
    dispatch_pkt_t d;
    d.fu_op   = e.fu_op;
    d.rd      = e.rd;
    d.rob     = e.rob;
    d.use_imm = e.use_imm;
    d.imm     = e.imm;
    d.rs1_val = v1;
    d.rs2_val = v2;
    return d;
  endfunction

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build the issue stage testbench with Verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_rs_issue_top \
  -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "All tests passed!" sim.log || { echo "no result in log"; exit 1; }
echo "simulation passed"
exit 0

//--- tb_rs_issue_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rs_issue_top;

  localparam int CLK_PERIOD  = 8;
  localparam int ARITH_DEPTH = rs_cfg_pkg::ARITH_DEPTH_DEF;
  localparam int MULT_DEPTH  = rs_cfg_pkg::MULT_DEPTH_DEF;
  localparam int NUM_TESTS   = 6;
  localparam int WAIT_LIMIT  = 20;

  logic                        clk;
  logic                        arst_n;
  logic                        flush;
  logic                        issue_valid;
  rs_types_pkg::issue_pkt_t    issue_pkt;
  logic                        issue_ready;
  rs_types_pkg::cdb_pkt_t      cdb;
  logic                        arith_valid;
  rs_types_pkg::dispatch_pkt_t arith_pkt;
  logic                        arith_ready;
  logic                        mult_valid;
  rs_types_pkg::dispatch_pkt_t mult_pkt;
  logic                        mult_ready;

  int          errors;
  int          test_errors;
  int          tests_run;
  int          tests_failed;
  logic [31:0] v5, v6, v9, v20;

  rs_issue_top #(.ARITH_DEPTH(ARITH_DEPTH), .MULT_DEPTH(MULT_DEPTH)) u_rs_issue_top (
    .clk         (clk),
    .arst_n      (arst_n),
    .flush       (flush),
    .issue_valid (issue_valid),
    .issue_pkt   (issue_pkt),
    .issue_ready (issue_ready),
    .cdb         (cdb),
    .arith_valid (arith_valid),
    .arith_pkt   (arith_pkt),
    .arith_ready (arith_ready),
    .mult_valid  (mult_valid),
    .mult_pkt    (mult_pkt),
    .mult_ready  (mult_ready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // 200 cycles per test
  initial begin
    #(NUM_TESTS * 200 * CLK_PERIOD);
    $display("watchdog expired before the tests finished");
    $display("Test failures found");
    $finish;
  end

  function automatic rs_types_pkg::issue_pkt_t make_issue(
      rs_types_pkg::fu_sel_e sel, rs_types_pkg::fu_op_e op,
      logic [rs_cfg_pkg::PREG_W-1:0] rs1, logic [rs_cfg_pkg::PREG_W-1:0] rs2,
      logic rdy1, logic rdy2, logic [rs_cfg_pkg::PREG_W-1:0] rd,
      logic [rs_cfg_pkg::ROB_W-1:0] rob);
    rs_types_pkg::issue_pkt_t p;
    p         = '0;
    p.fu_sel  = sel;
    p.fu_op   = op;
    p.rs1     = rs1;
    p.rs2     = rs2;
    p.rs1_rdy = rdy1;
    p.rs2_rdy = rdy2;
    p.rd      = rd;
    p.rob     = rob;
    return p;
  endfunction

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got 0x%0h, expected 0x%0h", $time, what, got, exp);
      test_errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
    end
    errors += test_errors;
    $display("%s finished with %0d errors", name, test_errors);
    test_errors = 0;
  endtask

  // holds issue_valid until accepted, returns just after the next falling edge
  task automatic issue_instr(input rs_types_pkg::issue_pkt_t p);
    int n;
    n           = 0;
    issue_pkt   = p;
    issue_valid = 1'b1;
    #1;
    while (!issue_ready && n < WAIT_LIMIT) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (!issue_ready) begin
      $display("instruction with rob %0d was never accepted", p.rob);
      test_errors++;
    end
    @(posedge clk);
    @(negedge clk);
    issue_valid = 1'b0;
  endtask

  task automatic broadcast(input logic [rs_cfg_pkg::PREG_W-1:0] tag, input logic [31:0] value);
    cdb.valid = 1'b1;
    cdb.tag   = tag;
    cdb.value = value;
    @(posedge clk);
    @(negedge clk);
    cdb = '0;
  endtask

  task automatic wait_dispatch(input logic is_mult);
    int n;
    n = 0;
    #1;
    while (!(is_mult ? mult_valid : arith_valid) && n < WAIT_LIMIT) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (!(is_mult ? mult_valid : arith_valid)) begin
      $display("no dispatch appeared on the %s port", is_mult ? "mult" : "arith");
      test_errors++;
    end
  endtask

  task automatic test_reset_state();
    issue_pkt = make_issue(rs_types_pkg::fu_arith, rs_types_pkg::op_add, 0, 0, 1, 1, 0, 0);
    #1;
    check("issue_ready after reset", issue_ready, 1);
    check("arith_valid after reset", arith_valid, 0);
    check("mult_valid after reset", mult_valid, 0);
    end_test("reset_state");
  endtask

  task automatic test_ready_operands();
    rs_types_pkg::issue_pkt_t p;
    v5 = $urandom();
    v6 = $urandom();
    broadcast(5, v5);
    broadcast(6, v6);
    p         = make_issue(rs_types_pkg::fu_arith, rs_types_pkg::op_add, 5, 6, 1, 1, 12, 3);
    p.use_imm = 1'b1;
    p.imm     = 32'h0000_0abc;
    issue_instr(p);
    #1; // one cycle after the accepting edge
    check("arith_valid after issue", arith_valid, 1);
    check("arith rs1 value", arith_pkt.rs1_val, v5);
    check("arith rs2 value", arith_pkt.rs2_val, v6);
    check("arith rd", arith_pkt.rd, 12);
    check("arith rob", arith_pkt.rob, 3);
    check("arith op", arith_pkt.fu_op, rs_types_pkg::op_add);
    check("arith use_imm", arith_pkt.use_imm, 1);
    check("arith imm", arith_pkt.imm, 32'h0000_0abc);
    check("mult_valid stays low", mult_valid, 0);
    @(negedge clk);
    #1;
    check("arith_valid after handoff", arith_valid, 0);
    end_test("ready_operands");
  endtask

  task automatic test_wakeup();
    rs_types_pkg::issue_pkt_t p;
    v9    = $urandom();
    p     = make_issue(rs_types_pkg::fu_mult, rs_types_pkg::op_mul, 9, 5, 0, 1, 13, 4);
    p.imm = 32'h0000_5a5a;
    issue_instr(p);
    repeat (3) begin
      #1;
      check("mult_valid while waiting on p9", mult_valid, 0);
      @(negedge clk);
    end
    broadcast(9, v9);
    wait_dispatch(1'b1);
    check("mult rs1 value", mult_pkt.rs1_val, v9);
    check("mult rs2 value", mult_pkt.rs2_val, v5);
    check("mult rob", mult_pkt.rob, 4);
    check("mult rd", mult_pkt.rd, 13);
    check("mult op", mult_pkt.fu_op, rs_types_pkg::op_mul);
    check("mult imm", mult_pkt.imm, 32'h0000_5a5a);
    check("arith_valid stays low", arith_valid, 0);
    // new p9 value on the bus this cycle reaches the presented entry
    v9        = $urandom();
    cdb.valid = 1'b1;
    cdb.tag   = 9;
    cdb.value = v9;
    #1;
    check("forwarded rs1 value", mult_pkt.rs1_val, v9);
    @(negedge clk);
    cdb = '0;
    #1;
    check("mult_valid after handoff", mult_valid, 0);
    end_test("wakeup_forwarding");
  endtask

  task automatic test_full_station();
    arith_ready = 1'b0;
    for (int i = 0; i < ARITH_DEPTH; i++) begin
      issue_instr(make_issue(rs_types_pkg::fu_arith, rs_types_pkg::op_sub, 20, 5, 0, 1,
                             16 + i, 8 + i));
    end
    issue_pkt = make_issue(rs_types_pkg::fu_arith, rs_types_pkg::op_add, 1, 2, 1, 1, 30, 20);
    #1;
    check("issue_ready for arith when full", issue_ready, 0);
    issue_pkt.fu_sel = rs_types_pkg::fu_comp;
    #1;
    check("issue_ready for comp when full", issue_ready, 0);
    issue_pkt.fu_sel = rs_types_pkg::fu_mult;
    #1;
    check("issue_ready for mult", issue_ready, 1);
    check("arith_valid while all wait", arith_valid, 0);
    end_test("full_station");
  endtask

  task automatic test_backpressure();
    v20 = $urandom();
    broadcast(20, v20);
    repeat (3) begin
      #1;
      check("arith_valid under back-pressure", arith_valid, 1);
      check("held rob", arith_pkt.rob, 8);
      check("held rs1 value", arith_pkt.rs1_val, v20);
      @(negedge clk);
    end
    arith_ready = 1'b1;
    for (int i = 0; i < ARITH_DEPTH; i++) begin
      #1;
      check($sformatf("valid of dispatch %0d", i), arith_valid, 1);
      check($sformatf("rob of dispatch %0d", i), arith_pkt.rob, 8 + i);
      check($sformatf("rs2 of dispatch %0d", i), arith_pkt.rs2_val, v5);
      @(negedge clk);
    end
    #1;
    check("arith_valid after drain", arith_valid, 0);
    end_test("backpressure_order");
  endtask

  task automatic test_flush();
    arith_ready = 1'b0;
    mult_ready  = 1'b0;
    issue_instr(make_issue(rs_types_pkg::fu_arith, rs_types_pkg::op_and, 34, 5, 0, 1, 44, 25));
    issue_instr(make_issue(rs_types_pkg::fu_comp, rs_types_pkg::op_slt, 5, 6, 1, 1, 40, 21));
    issue_instr(make_issue(rs_types_pkg::fu_arith, rs_types_pkg::op_xor, 33, 5, 0, 1, 42, 23));
    issue_instr(make_issue(rs_types_pkg::fu_mult, rs_types_pkg::op_mulh, 6, 5, 1, 1, 41, 22));
    issue_instr(make_issue(rs_types_pkg::fu_mult, rs_types_pkg::op_mul, 5, 6, 1, 1, 45, 26));
    #1;
    check("arith rob before lower wakeup", arith_pkt.rob, 21);
    broadcast(34, $urandom()); // entry 0 wakes while entry 1 is stalled
    #1;
    check("arith_valid before flush", arith_valid, 1);
    check("held rob after lower wakeup", arith_pkt.rob, 21);
    check("mult_valid before flush", mult_valid, 1);
    check("issue_ready for mult when full", issue_ready, 0);
    flush = 1'b1;
    @(posedge clk);
    @(negedge clk);
    flush     = 1'b0;
    issue_pkt = make_issue(rs_types_pkg::fu_mult, rs_types_pkg::op_mul, 1, 2, 1, 1, 43, 24);
    #1;
    check("arith_valid after flush", arith_valid, 0);
    check("mult_valid after flush", mult_valid, 0);
    check("issue_ready after flush", issue_ready, 1);
    arith_ready = 1'b1;
    mult_ready  = 1'b1;
    broadcast(33, $urandom()); // flushed entry must not wake
    #1;
    check("arith_valid after late broadcast", arith_valid, 0);
    end_test("flush");
  endtask

  initial begin
    void'($urandom(32'he5cc));
    clk          = 1'b0;
    arst_n       = 1'b0;
    flush        = 1'b0;
    issue_valid  = 1'b0;
    issue_pkt    = '0;
    cdb          = '0;
    arith_ready  = 1'b1;
    mult_ready   = 1'b1;
    errors       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    test_reset_state();
    test_ready_operands();
    test_wakeup();
    test_full_station();
    test_backpressure();
    test_flush();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire
